// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -j 0
TOP       = rv_core_tb
FILELIST  = build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

// ==== build.f ====
rtl/rv_pkg.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/regfile.sv
rtl/exe_stage.sv
rtl/data_mem.sv
rtl/rv_core.sv
sim/rv_core_assert.sv
sim/rv_core_tb.sv

// ==== rtl/data_mem.sv ====
// doubleword data memory
module data_mem (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::mem_req_t        mem_req,
  output logic [rv_pkg::xlen-1:0] load_data
);

  import rv_pkg::*;

  logic [xlen-1:0]                mem [dmem_words];
  logic [$clog2(dmem_words)-1:0]  idx;
  logic [5:0]                     bit_off;
  logic [xlen-1:0]                wdata_sh;
  logic [xlen-1:0]                rdata_sh;

  // address bits 10:3 pick the doubleword
  assign idx      = mem_req.addr[$clog2(dmem_words)+2:3];
  assign bit_off  = {mem_req.addr[2:0], 3'b000};
  assign wdata_sh = mem_req.wdata << bit_off;
  assign rdata_sh = mem[idx] >> bit_off;

  always_ff @(posedge clk) begin
    if (!rst && mem_req.wen) begin
      for (int i = 0; i < xlen / 8; i++) begin
        if (mem_req.wmask[8*i]) begin
          mem[idx][8*i +: 8] <= wdata_sh[8*i +: 8];
        end
      end
    end
  end

  // funct3[1:0] gives the size, bit 2 the zero extension
  always_comb begin
    load_data = '0;
    if (mem_req.ren) begin
      case ({1'b0, mem_req.funct3[1:0]})
        funct3_sb: load_data = mem_req.is_unsigned ? {56'b0, rdata_sh[7:0]}
                                                   : {{56{rdata_sh[7]}}, rdata_sh[7:0]};
        funct3_sh: load_data = mem_req.is_unsigned ? {48'b0, rdata_sh[15:0]}
                                                   : {{48{rdata_sh[15]}}, rdata_sh[15:0]};
        funct3_sw: load_data = mem_req.is_unsigned ? {32'b0, rdata_sh[31:0]}
                                                   : {{32{rdata_sh[31]}}, rdata_sh[31:0]};
        funct3_sd: load_data = rdata_sh;
        default:   load_data = rdata_sh;
      endcase
    end
  end

endmodule

// ==== rtl/exe_stage.sv ====
// alu, branch and write-back
module exe_stage (
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       pc,
  input  rv_pkg::ex_req_t               ex_req,
  input  logic [rv_pkg::xlen-1:0]       load_data,
  output logic                          redirect,
  output logic [rv_pkg::xlen-1:0]       redirect_pc,
  output logic                          wen,
  output logic [rv_pkg::reg_addr_w-1:0] rd,
  output logic [rv_pkg::xlen-1:0]       wb_data
);

  import rv_pkg::*;

  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [5:0]      shamt;
  logic            sub_op;
  logic [xlen-1:0] sra_res;
  logic [xlen-1:0] alu_res;
  logic            cond;
  logic            taken;
  logic [xlen-1:0] target;

  assign op1     = ex_req.op1;
  assign op2     = ex_req.op2;
  assign shamt   = op2[5:0];
  // op-imm has no subtract, funct7 there is immediate
  assign sub_op  = (ex_req.opcode == opcode_op) && ex_req.funct7[5];
  assign sra_res = $signed(op1) >>> shamt;

  always_comb begin
    case (ex_req.funct3)
      funct3_add_sub: alu_res = sub_op ? op1 - op2 : op1 + op2;
      funct3_sll:     alu_res = op1 << shamt;
      funct3_slt:     alu_res = {63'b0, $signed(op1) < $signed(op2)};
      funct3_sltu:    alu_res = {63'b0, op1 < op2};
      funct3_xor:     alu_res = op1 ^ op2;
      funct3_srl_sra: alu_res = ex_req.funct7[5] ? sra_res : op1 >> shamt;
      funct3_or:      alu_res = op1 | op2;
      funct3_and:     alu_res = op1 & op2;
      default:        alu_res = op1 + op2;
    endcase
  end

  always_comb begin
    case (ex_req.funct3)
      funct3_beq:  cond = (op1 == op2);
      funct3_bne:  cond = (op1 != op2);
      funct3_blt:  cond = ($signed(op1) < $signed(op2));
      funct3_bge:  cond = ($signed(op1) >= $signed(op2));
      funct3_bltu: cond = (op1 < op2);
      funct3_bgeu: cond = (op1 >= op2);
      default:     cond = 1'b0;
    endcase
  end

  always_comb begin
    taken  = 1'b0;
    target = ex_req.t1;
    if (ex_req.opcode == opcode_jal) begin
      taken  = 1'b1;
      target = op2;
    end else if (ex_req.opcode == opcode_jalr) begin
      taken  = 1'b1;
      target = (op1 + op2) & ~64'd1;
    end else if (ex_req.inst_type == inst_b) begin
      taken  = cond;
    end
  end

  // next pc, fall-through when not taken
  assign redirect    = !rst && taken;
  assign redirect_pc = taken ? target : pc + 64'd4;

  always_comb begin
    case (ex_req.opcode)
      opcode_load:               wb_data = load_data;
      opcode_jal:                wb_data = op1;
      opcode_jalr:               wb_data = ex_req.t1;
      opcode_lui, opcode_auipc:  wb_data = op1 + op2;
      default:                   wb_data = alu_res;
    endcase
  end

  assign rd  = ex_req.rd;
  assign wen = ex_req.rd_wen && (ex_req.rd != '0);

endmodule

// ==== rtl/id_stage.sv ====
// instruction decode
module id_stage (
  input  logic                          rst,
  input  logic [31:0]                   inst,
  input  logic [rv_pkg::xlen-1:0]       pc,
  input  logic [rv_pkg::xlen-1:0]       rs1_data,
  input  logic [rv_pkg::xlen-1:0]       rs2_data,
  output logic                          rs1_ren,
  output logic [rv_pkg::reg_addr_w-1:0] rs1_raddr,
  output logic                          rs2_ren,
  output logic [rv_pkg::reg_addr_w-1:0] rs2_raddr,
  output rv_pkg::ex_req_t               ex_req,
  output rv_pkg::mem_req_t              mem_req
);

  import rv_pkg::*;

  logic [4:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [4:0]      rd;
  inst_type_t      itype;
  logic [31:0]     imm_i;
  logic [31:0]     imm_s;
  logic [31:0]     imm_b;
  logic [31:0]     imm_u;
  logic [31:0]     imm_j;
  logic [31:0]     imm32;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] t1;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] size_mask;
  logic            rd_wen;

  assign opcode    = inst[6:2];
  assign rd        = inst[11:7];
  assign funct3    = inst[14:12];
  assign rs1_raddr = inst[19:15];
  assign rs2_raddr = inst[24:20];
  assign funct7    = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      opcode_lui, opcode_auipc:  itype = inst_u;
      opcode_jal:                itype = inst_j;
      opcode_branch:             itype = inst_b;
      opcode_store:              itype = inst_s;
      opcode_op:                 itype = inst_r;
      opcode_jalr, opcode_load,
      opcode_op_imm, opcode_fence,
      opcode_env:                itype = inst_i;
      default:                   itype = inst_none;
    endcase
  end

  always_comb begin
    case (itype)
      inst_i:  imm32 = imm_i;
      inst_s:  imm32 = imm_s;
      inst_b:  imm32 = imm_b;
      inst_u:  imm32 = imm_u;
      inst_j:  imm32 = imm_j;
      default: imm32 = '0;
    endcase
  end
  assign imm = {{32{imm32[31]}}, imm32};

  // enables are held low in reset
  assign rs1_ren = !rst && (itype inside {inst_r, inst_i, inst_s, inst_b});
  assign rs2_ren = !rst && (itype inside {inst_r, inst_s, inst_b});
  assign rd_wen  = !rst && (itype inside {inst_r, inst_i, inst_u, inst_j})
                   && (opcode != opcode_fence) && (opcode != opcode_env);

  always_comb begin
    op1 = '0;
    op2 = '0;
    case (itype)
      inst_r, inst_b: begin
        op1 = rs1_data;
        op2 = rs2_data;
      end
      inst_i: begin
        op1 = rs1_data;
        op2 = imm;
      end
      // link value and jump target
      inst_j: begin
        op1 = pc + 64'd4;
        op2 = pc + imm;
      end
      // lui adds to zero, auipc to pc
      inst_u: begin
        op1 = (opcode == opcode_auipc) ? pc : '0;
        op2 = imm;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (opcode)
      opcode_jalr:   t1 = pc + 64'd4;
      opcode_branch: t1 = pc + imm;
      default:       t1 = '0;
    endcase
  end

  assign ex_req = '{
    inst_type: itype,
    opcode:    opcode,
    funct3:    funct3,
    funct7:    funct7,
    op1:       op1,
    op2:       op2,
    t1:        t1,
    rd:        rd,
    rd_wen:    rd_wen
  };

  assign mem_addr = rs1_data + imm;

  always_comb begin
    case (funct3)
      funct3_sb: size_mask = 64'h0000_0000_0000_00ff;
      funct3_sh: size_mask = 64'h0000_0000_0000_ffff;
      funct3_sw: size_mask = 64'h0000_0000_ffff_ffff;
      funct3_sd: size_mask = 64'hffff_ffff_ffff_ffff;
      default:   size_mask = '0;
    endcase
  end

  assign mem_req = '{
    ren:         !rst && (opcode == opcode_load),
    wen:         !rst && (itype == inst_s),
    addr:        mem_addr,
    wdata:       rs2_data,
    wmask:       (itype == inst_s) ? (size_mask << {mem_addr[2:0], 3'b000}) : '0,
    funct3:      funct3,
    is_unsigned: funct3[2]
  };

endmodule

// ==== rtl/if_stage.sv ====
// program counter
module if_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    redirect,
  input  logic [rv_pkg::xlen-1:0] redirect_pc,
  output logic [rv_pkg::xlen-1:0] pc
);

  import rv_pkg::*;

  logic [xlen-1:0] pc_next;

  // taken branch or jump wins over fall-through
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else begin
      pc_next = pc + 64'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== rtl/regfile.sv ====
// integer register file
module regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_raddr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_raddr,
  input  logic                          rs1_ren,
  input  logic                          rs2_ren,
  input  logic                          wen,
  input  logic [rv_pkg::reg_addr_w-1:0] waddr,
  input  logic [rv_pkg::xlen-1:0]       wdata,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data
);

  import rv_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (!rst && wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  always_comb begin
    if (rs1_ren && (rs1_raddr != '0)) begin
      rs1_data = regs[rs1_raddr];
    end else begin
      rs1_data = '0;
    end
  end

  always_comb begin
    if (rs2_ren && (rs2_raddr != '0)) begin
      rs2_data = regs[rs2_raddr];
    end else begin
      rs2_data = '0;
    end
  end

endmodule

// ==== rtl/rv_core.sv ====
// single-cycle rv64i core
module rv_core (
  input  logic                    clk,
  input  logic                    rst,
  output logic [rv_pkg::xlen-1:0] inst_addr,
  input  logic [31:0]             inst,
  output rv_pkg::retire_t         retire
);

  import rv_pkg::*;

  logic [xlen-1:0]       pc;
  logic                  redirect;
  logic [xlen-1:0]       redirect_pc;
  logic                  rs1_ren;
  logic                  rs2_ren;
  logic [reg_addr_w-1:0] rs1_raddr;
  logic [reg_addr_w-1:0] rs2_raddr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  ex_req_t               ex_req;
  mem_req_t              mem_req;
  logic [xlen-1:0]       load_data;
  logic                  wen;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       wb_data;

  if_stage if_stage_i (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (pc)
  );

  id_stage id_stage_i (
    .rst       (rst),
    .inst      (inst),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1_ren   (rs1_ren),
    .rs1_raddr (rs1_raddr),
    .rs2_ren   (rs2_ren),
    .rs2_raddr (rs2_raddr),
    .ex_req    (ex_req),
    .mem_req   (mem_req)
  );

  regfile regfile_i (
    .clk       (clk),
    .rst       (rst),
    .rs1_raddr (rs1_raddr),
    .rs2_raddr (rs2_raddr),
    .rs1_ren   (rs1_ren),
    .rs2_ren   (rs2_ren),
    .wen       (wen),
    .waddr     (rd),
    .wdata     (wb_data),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  exe_stage exe_stage_i (
    .rst         (rst),
    .pc          (pc),
    .ex_req      (ex_req),
    .load_data   (load_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .wen         (wen),
    .rd          (rd),
    .wb_data     (wb_data)
  );

  data_mem data_mem_i (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .load_data (load_data)
  );

  assign inst_addr = pc;

  // trace of the instruction committing at the next edge
  assign retire = '{
    valid: !rst,
    pc:    pc,
    rd:    rd,
    wen:   wen,
    data:  wb_data
  };

endmodule

// ==== rtl/rv_pkg.sv ====
// rv64i core definitions
package rv_pkg;

  localparam int xlen       = 64;
  localparam int reg_addr_w = 5;
  localparam int dmem_words = 256;

  // major opcodes, inst[6:2]
  localparam logic [4:0] opcode_lui    = 5'b01101;
  localparam logic [4:0] opcode_auipc  = 5'b00101;
  localparam logic [4:0] opcode_jal    = 5'b11011;
  localparam logic [4:0] opcode_jalr   = 5'b11001;
  localparam logic [4:0] opcode_branch = 5'b11000;
  localparam logic [4:0] opcode_load   = 5'b00000;
  localparam logic [4:0] opcode_store  = 5'b01000;
  localparam logic [4:0] opcode_op_imm = 5'b00100;
  localparam logic [4:0] opcode_op     = 5'b01100;
  localparam logic [4:0] opcode_fence  = 5'b00011;
  localparam logic [4:0] opcode_env    = 5'b11100;

  // access size, loads use the same code in funct3[1:0]
  localparam logic [2:0] funct3_sb = 3'b000;
  localparam logic [2:0] funct3_sh = 3'b001;
  localparam logic [2:0] funct3_sw = 3'b010;
  localparam logic [2:0] funct3_sd = 3'b011;

  // branch conditions
  localparam logic [2:0] funct3_beq  = 3'b000;
  localparam logic [2:0] funct3_bne  = 3'b001;
  localparam logic [2:0] funct3_blt  = 3'b100;
  localparam logic [2:0] funct3_bge  = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

  // alu functions of op and op-imm
  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_sll     = 3'b001;
  localparam logic [2:0] funct3_slt     = 3'b010;
  localparam logic [2:0] funct3_sltu    = 3'b011;
  localparam logic [2:0] funct3_xor     = 3'b100;
  localparam logic [2:0] funct3_srl_sra = 3'b101;
  localparam logic [2:0] funct3_or      = 3'b110;
  localparam logic [2:0] funct3_and     = 3'b111;

  typedef enum logic [2:0] {
    inst_none = 3'd0,
    inst_r    = 3'd1,
    inst_i    = 3'd2,
    inst_s    = 3'd3,
    inst_b    = 3'd4,
    inst_u    = 3'd5,
    inst_j    = 3'd6
  } inst_type_t;

  typedef struct packed {
    inst_type_t            inst_type;
    logic [4:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [xlen-1:0]       op1;
    logic [xlen-1:0]       op2;
    logic [xlen-1:0]       t1;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_wen;
  } ex_req_t;

  typedef struct packed {
    logic            ren;
    logic            wen;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] wmask;
    logic [2:0]      funct3;
    logic            is_unsigned;
  } mem_req_t;

  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rd;
    logic                  wen;
    logic [xlen-1:0]       data;
  } retire_t;

endpackage

// ==== sim/rv_core_assert.sv ====
// retire trace properties
module rv_core_assert (
  input logic                    clk,
  input logic                    rst,
  input logic [rv_pkg::xlen-1:0] inst_addr,
  input rv_pkg::retire_t         retire
);
  timeunit 1ns;
  timeprecision 100ps;

  import rv_pkg::*;

  valid_low_in_reset: assert property (@(posedge clk) rst |-> !retire.valid)
    else $error("retire valid high during reset");

  // fetch stays word aligned
  pc_aligned: assert property (@(posedge clk) disable iff (rst) inst_addr[1:0] == 2'b00)
    else $error("pc not word aligned");

  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    retire.wen |-> retire.rd != '0)
    else $error("write enable set for x0");

endmodule

bind rv_core rv_core_assert assert_i (
  .clk       (clk),
  .rst       (rst),
  .inst_addr (inst_addr),
  .retire    (retire)
);

// ==== sim/rv_core_tb.sv ====
// rv64i core testbench
module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import rv_pkg::*;

  localparam int prog_len = 400;
  localparam int max_cycles = 4000;

  logic            clk;
  logic            rst;
  logic [63:0]     inst_addr;
  logic [31:0]     inst;
  retire_t         retire;

  logic [31:0] rom [prog_len];
  logic [63:0] m_regs [32];
  logic [7:0]  m_mem [2048];
  logic [63:0] m_pc;
  integer      seed;
  int          errors;
  int          retired;
  logic        done;
  logic        timed_out;

  rv_core dut_i (
    .clk       (clk),
    .rst       (rst),
    .inst_addr (inst_addr),
    .inst      (inst),
    .retire    (retire)
  );

  // combinational fetch, nop outside the program
  assign inst = (inst_addr < 64'(prog_len * 4)) ? rom[inst_addr[10:2]] : 32'h0000_0013;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int unsigned pick(input int unsigned n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // never x1, which stays the memory base
  function automatic logic [4:0] pick_rd();
    if (pick(8) == 0) begin
      return 5'd0;
    end
    return 5'(2 + pick(30));
  endfunction

  // forward target index, clamped to the last instruction
  function automatic int fwd_target(input int i);
    int t;
    t = i + 1 + int'(pick(6));
    if (t > prog_len - 1) begin
      t = prog_len - 1;
    end
    return t;
  endfunction

  task automatic build_program();
    int i;
    int sz;
    int off;
    int t;
    logic [2:0] f3;
    logic [2:0] bf3 [6];
    bf3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    i = 0;
    rom[i] = enc_i(12'd0, 5'd0, 3'd0, 5'd1, 7'h13);
    i++;
    for (int r = 2; r < 32; r++) begin
      if (r % 2 == 0) begin
        rom[i] = {20'(pick(32'h10_0000)), 5'(r), 7'h37};
      end else begin
        rom[i] = enc_i(12'(pick(4096)), 5'd0, 3'd0, 5'(r), 7'h13);
      end
      i++;
    end
    // fill both memory windows before any load
    for (int w = 0; w < 2; w++) begin
      if (w == 1) begin
        rom[i] = enc_i(12'd1024, 5'd0, 3'd0, 5'd1, 7'h13);
        i++;
      end
      for (int k = 0; k < 16; k++) begin
        rom[i] = enc_s(12'(k * 8), 5'(2 + pick(30)), 5'd1, 3'd3);
        i++;
      end
    end
    while (i < prog_len - 1) begin
      case (pick(12))
        0, 1: begin
          f3 = 3'(pick(8));
          rom[i] = enc_r(((f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1) ? 7'h20 : 7'h00,
                         5'(pick(32)), 5'(pick(32)), f3, pick_rd(), 7'h33);
        end
        2, 3: begin
          f3 = 3'(pick(8));
          if (f3 == 3'd1) begin
            off = int'(pick(64));
          end else if (f3 == 3'd5) begin
            off = int'(pick(64)) + ((pick(2) == 1) ? 1024 : 0);
          end else begin
            off = int'(pick(4096));
          end
          rom[i] = enc_i(12'(off), 5'(pick(32)), f3, pick_rd(), 7'h13);
        end
        4: rom[i] = {20'(pick(32'h10_0000)), pick_rd(), (pick(2) == 1) ? 7'h37 : 7'h17};
        5: begin
          f3 = 3'(pick(7));
          sz = 1 << f3[1:0];
          off = int'(pick(128 / sz)) * sz;
          rom[i] = enc_i(12'(off), 5'd1, f3, pick_rd(), 7'h03);
        end
        6: begin
          f3 = 3'(pick(4));
          sz = 1 << f3[1:0];
          off = int'(pick(128 / sz)) * sz;
          rom[i] = enc_s(12'(off), 5'(pick(32)), 5'd1, f3);
        end
        7: begin
          t = fwd_target(i);
          off = int'(pick(32));
          rom[i] = enc_b(13'((t - i) * 4), (pick(4) == 0) ? 5'(off) : 5'(pick(32)),
                         5'(off), bf3[pick(6)]);
        end
        8: rom[i] = enc_j(21'((fwd_target(i) - i) * 4), pick_rd());
        // low bit of the target is set now and then
        9: rom[i] = enc_i(12'(fwd_target(i) * 4 + int'(pick(2))), 5'd0, 3'd0,
                          pick_rd(), 7'h67);
        10: rom[i] = enc_i((pick(2) == 1) ? 12'd1024 : 12'd0, 5'd0, 3'd0, 5'd1, 7'h13);
        default: begin
          if (pick(3) == 0) begin
            rom[i] = (pick(2) == 1) ? 32'h0000_000f : 32'h0000_0073;
          end else begin
            rom[i] = enc_i(12'(pick(4096)), 5'(pick(32)), 3'd0, 5'd0, 7'h13);
          end
        end
      endcase
      i++;
    end
    rom[prog_len - 1] = enc_j(21'd0, 5'd0);
  endtask

  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic [63:0] a,
                                          input logic [63:0] b, input logic sub,
                                          input logic arith);
    logic [5:0]  sh;
    logic [63:0] res;
    sh = b[5:0];
    case (f3)
      3'd0: res = sub ? a - b : a + b;
      3'd1: res = a << sh;
      3'd2: res = {63'd0, $signed(a) < $signed(b)};
      3'd3: res = {63'd0, a < b};
      3'd4: res = a ^ b;
      3'd5: begin
        if (arith) begin
          res = $signed(a) >>> sh;
        end else begin
          res = a >> sh;
        end
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // architectural step of one instruction at m_pc
  function automatic retire_t ref_step(input logic [31:0] ins);
    retire_t     r;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_u;
    logic [63:0] imm_j;
    logic [63:0] nxt;
    logic [63:0] val;
    logic [63:0] addr;
    logic        wr;
    logic        cond;
    int          nbytes;
    int          base;
    f3 = ins[14:12];
    rd = ins[11:7];
    a = m_regs[ins[19:15]];
    b = m_regs[ins[24:20]];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
    imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt = m_pc + 64'd4;
    wr = 1'b0;
    val = '0;
    nbytes = 1 << f3[1:0];
    case (ins[6:0])
      7'h37: begin
        wr = 1'b1;
        val = imm_u;
      end
      7'h17: begin
        wr = 1'b1;
        val = m_pc + imm_u;
      end
      7'h6f: begin
        wr = 1'b1;
        val = m_pc + 64'd4;
        nxt = m_pc + imm_j;
      end
      7'h67: begin
        wr = 1'b1;
        val = m_pc + 64'd4;
        nxt = (a + imm_i) & ~64'd1;
      end
      7'h63: begin
        case (f3)
          3'd0: cond = (a == b);
          3'd1: cond = (a != b);
          3'd4: cond = ($signed(a) < $signed(b));
          3'd5: cond = ($signed(a) >= $signed(b));
          3'd6: cond = (a < b);
          default: cond = (a >= b);
        endcase
        if (cond) nxt = m_pc + imm_b;
      end
      7'h03: begin
        wr = 1'b1;
        addr = a + imm_i;
        base = int'(addr[10:0]);
        for (int k = 0; k < nbytes; k++) val[8*k +: 8] = m_mem[base + k];
        if (!f3[2]) begin
          case (f3[1:0])
            2'd0: val = {{56{val[7]}}, val[7:0]};
            2'd1: val = {{48{val[15]}}, val[15:0]};
            2'd2: val = {{32{val[31]}}, val[31:0]};
            default: ;
          endcase
        end
      end
      7'h23: begin
        addr = a + imm_s;
        base = int'(addr[10:0]);
        for (int k = 0; k < nbytes; k++) m_mem[base + k] = b[8*k +: 8];
      end
      7'h13: begin
        wr = 1'b1;
        val = alu_ref(f3, a, imm_i, 1'b0, ins[30]);
      end
      7'h33: begin
        wr = 1'b1;
        val = alu_ref(f3, a, b, ins[30], ins[30]);
      end
      default: ;
    endcase
    if (rd == 5'd0) wr = 1'b0;
    if (wr) m_regs[rd] = val;
    r = '{valid: 1'b1, pc: m_pc, rd: rd, wen: wr, data: val};
    m_pc = nxt;
    return r;
  endfunction

  // retire is stable mid-cycle, ahead of the commit edge
  always @(negedge clk) begin
    retire_t exp;
    if (!rst && !done) begin
      exp = ref_step(rom[m_pc[10:2]]);
      retired++;
      if (retire.valid !== 1'b1) begin
        $display("ERR valid expected 1 actual %b", retire.valid);
        errors++;
      end
      if (retire.pc !== exp.pc) begin
        $display("ERR pc expected %h actual %h", exp.pc, retire.pc);
        errors++;
      end
      if (inst_addr !== exp.pc) begin
        $display("ERR inst_addr expected %h actual %h", exp.pc, inst_addr);
        errors++;
      end
      if (retire.wen !== exp.wen) begin
        $display("ERR wen at pc %h expected %b actual %b", exp.pc, exp.wen, retire.wen);
        errors++;
      end
      if (exp.wen && retire.rd !== exp.rd) begin
        $display("ERR rd at pc %h expected %0d actual %0d", exp.pc, exp.rd, retire.rd);
        errors++;
      end
      if (exp.wen && retire.data !== exp.data) begin
        $display("ERR data at pc %h expected %h actual %h", exp.pc, exp.data, retire.data);
        errors++;
      end
      if (exp.pc == 64'((prog_len - 1) * 4)) done = 1'b1;
    end
  end

  initial begin
    int cycles;
    seed = 32'hc660_0e6d;
    rst = 1'b1;
    errors = 0;
    retired = 0;
    done = 1'b0;
    timed_out = 1'b0;
    m_pc = '0;
    for (int r = 0; r < 32; r++) m_regs[r] = '0;
    for (int k = 0; k < 2048; k++) m_mem[k] = '0;
    build_program();
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    cycles = 0;
    while (!done && cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout, the end of the program was never retired");
      timed_out = 1'b1;
    end
    $display("retired %0d errors %0d", retired, errors + int'(timed_out));
    if (errors == 0 && !timed_out) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
